/* vlog.f */
+incdir+dv
hw/exec_pkg.sv
hw/exec_control.sv
hw/operand_select.sv
hw/int_alu.sv
hw/exec_retire.sv
hw/execute_stage.sv
dv/execute_stage_tb.sv

/* Makefile */
TOP = execute_stage_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^all tests passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* dv/exec_vectors.svh */
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

    localparam int NUM_VECTORS = 31;

    // Columns: opcode, ALU op, rs1, rs2, immediate, {reg_write, mem_read, mem_write},
    // mode (0 plain, 1 flush in CALC, 2 second enable in CALC),
    // expected ALU result, expected taken, expected target.
    // Operands the opcode ignores get random fill; pc is PC_BASE where it counts
    vector_t vectors [NUM_VECTORS] = '{
        // Register and immediate ALU ops
        '{OP_OP,     ALU_ADD,  64'd100,  64'd23, 64'h0,   3'b100, 2'd0, 64'd123, 1'b0, 64'h0},
        '{OP_OP,     ALU_SUB,  64'd5,    64'd7,  64'h0,   3'b100, 2'd2, -64'h2,  1'b0, 64'h0},
        '{OP_OP_IMM, ALU_AND,  64'hf0f0, 64'h0,  64'hff00, 3'b100, 2'd0, 64'hf000, 1'b0, 64'h0},
        '{OP_OP_IMM, ALU_OR,   64'hf0f0, 64'h0,  64'h0f0f, 3'b100, 2'd0, 64'hffff, 1'b0, 64'h0},
        '{OP_OP,     ALU_XOR,  64'hff00, 64'h0ff0, 64'h0, 3'b100, 2'd0, 64'hf0f0, 1'b0, 64'h0},
        // Shift amount 68 keeps only its low 6 bits
        '{OP_OP_IMM, ALU_SLL,  64'h1,    64'h0,  64'd68,  3'b100, 2'd0, 64'h10,  1'b0, 64'h0},
        '{OP_OP,     ALU_SRL,  -64'h100, 64'd63, 64'h0,   3'b100, 2'd0, 64'h1,   1'b0, 64'h0},
        '{OP_OP,     ALU_SRA,  -64'h100, 64'd63, 64'h0,   3'b100, 2'd0, -64'h1,  1'b0, 64'h0},
        '{OP_OP_IMM, ALU_SRA,  -64'h100, 64'h0,  64'h4,   3'b100, 2'd0, -64'h10, 1'b0, 64'h0},
        // Mixed signs split SLT from SLTU
        '{OP_OP,     ALU_SLT,  -64'h1,   64'h1,  64'h0,   3'b100, 2'd0, 64'h1,   1'b0, 64'h0},
        '{OP_OP,     ALU_SLTU, -64'h1,   64'h1,  64'h0,   3'b100, 2'd0, 64'h0,   1'b0, 64'h0},
        // Upper immediate and address forms
        '{OP_LUI,    ALU_ADD,  64'h0,    64'h0,  -64'h12000, 3'b100, 2'd0, -64'h12000, 1'b0, 64'h0},
        '{OP_AUIPC,  ALU_AND,  64'h0,    64'h0,  64'h2000, 3'b100, 2'd0, 64'h6000, 1'b0, 64'h0},
        '{OP_LOAD,   ALU_SUB,  64'h2000, 64'h0,  -64'h8,  3'b110, 2'd0, 64'h1ff8, 1'b0, 64'h0},
        '{OP_STORE,  ALU_ADD,  64'h3000, 64'h0,  -64'h10, 3'b001, 2'd0, 64'h2ff0, 1'b0, 64'h0},
        // Branches, taken then not taken
        '{OP_BRANCH, ALU_EQ,   64'd7,    64'd7,  64'h40,  3'b000, 2'd0, 64'h1, 1'b1, 64'h4040},
        '{OP_BRANCH, ALU_EQ,   64'd7,    64'd8,  64'h40,  3'b000, 2'd0, 64'h0, 1'b0, 64'h0},
        '{OP_BRANCH, ALU_NE,   64'd7,    64'd8,  64'h40,  3'b000, 2'd0, 64'h1, 1'b1, 64'h4040},
        '{OP_BRANCH, ALU_NE,   64'd7,    64'd7,  64'h40,  3'b000, 2'd0, 64'h0, 1'b0, 64'h0},
        '{OP_BRANCH, ALU_SLT,  -64'h5,   64'h3,  -64'h20, 3'b000, 2'd0, 64'h1, 1'b1, 64'h3fe0},
        '{OP_BRANCH, ALU_SLT,  64'h3,    -64'h5, -64'h20, 3'b000, 2'd0, 64'h0, 1'b0, 64'h0},
        '{OP_BRANCH, ALU_GE,   64'h3,    -64'h5, 64'h40,  3'b000, 2'd0, 64'h1, 1'b1, 64'h4040},
        '{OP_BRANCH, ALU_GE,   -64'h5,   64'h3,  64'h40,  3'b000, 2'd0, 64'h0, 1'b0, 64'h0},
        '{OP_BRANCH, ALU_SLTU, 64'h3,    -64'h5, -64'h20, 3'b000, 2'd0, 64'h1, 1'b1, 64'h3fe0},
        '{OP_BRANCH, ALU_SLTU, -64'h5,   64'h3,  -64'h20, 3'b000, 2'd0, 64'h0, 1'b0, 64'h0},
        '{OP_BRANCH, ALU_GEU,  -64'h5,   64'h3,  64'h40,  3'b000, 2'd0, 64'h1, 1'b1, 64'h4040},
        '{OP_BRANCH, ALU_GEU,  64'h3,    -64'h5, 64'h40,  3'b000, 2'd0, 64'h0, 1'b0, 64'h0},
        // Jumps link to pc + 4
        '{OP_JAL,    ALU_XOR,  64'h0,    64'h0,  64'h100, 3'b100, 2'd0, 64'h4004, 1'b1, 64'h4100},
        '{OP_JALR,   ALU_ADD,  64'h8000, 64'h0,  64'h10,  3'b100, 2'd0, 64'h4004, 1'b1, 64'h8010},
        // Flushed row leaves the JALR result, next row recovers
        '{OP_OP,     ALU_ADD,  64'h1,    64'h2,  64'h0,   3'b100, 2'd1, 64'h0,  1'b0, 64'h0},
        '{OP_OP,     ALU_ADD,  64'h11,   64'h22, 64'h0,   3'b100, 2'd0, 64'h33, 1'b0, 64'h0}
    };

`endif

/* dv/execute_stage_tb.sv */
`timescale 1ns/1ps

module execute_stage_tb;

    import exec_pkg::*;

    localparam logic [XLEN-1:0] PC_BASE = 64'h4000;
    // Sampling edge to the edge that registers done
    localparam int              LATENCY      = 2;
    localparam int              DONE_TIMEOUT = 10;
    localparam logic [1:0]      MODE_FLUSH   = 2'd1;
    localparam logic [1:0]      MODE_EXTRA   = 2'd2;

    // One table row
    typedef struct packed {
        opcode_t         op;
        alu_op_t         alu;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] immed;
        logic [2:0]      flags;
        logic [1:0]      mode;
        logic [XLEN-1:0] exp_result;
        logic            exp_taken;
        logic [XLEN-1:0] exp_target;
    } vector_t;

    `include "exec_vectors.svh"

    logic         clk;
    logic         reset;
    logic         execute_enable;
    logic         flush;
    exec_req_t    req;
    exec_result_t result;
    logic         execute_done;

    int           errors;
    int           failed_tests;
    logic [31:0]  seed_value;

    execute_stage i_execute_stage (
        .clk            (clk),
        .reset          (reset),
        .execute_enable (execute_enable),
        .flush          (flush),
        .req            (req),
        .result         (result),
        .execute_done   (execute_done)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    function automatic logic [XLEN-1:0] random_word();
        return {$urandom(), $urandom()};
    endfunction

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    // Acts as the decoder: row fields plus random fill for unused operands
    task automatic load_request(input vector_t v);
        logic [31:0] fill;
        fill = $urandom();
        req.pc      = (v.op inside {OP_AUIPC, OP_BRANCH, OP_JAL, OP_JALR}) ? PC_BASE
                                                                         : random_word();
        req.rs1_val = (v.op inside {OP_LUI, OP_AUIPC, OP_JAL}) ? random_word() : v.rs1;
        req.rs2_val = (v.op inside {OP_OP, OP_BRANCH}) ? v.rs2 : random_word();
        req.ctrl.op_code       = v.op;
        req.ctrl.alu_op        = v.alu;
        req.ctrl.jump_if       = (v.op == OP_BRANCH) ? JUMP_BR
                               : (v.op inside {OP_JAL, OP_JALR}) ? JUMP_YES : JUMP_NONE;
        req.ctrl.jump_absolute = (v.op == OP_JALR);
        req.ctrl.alu_use_immed = !(v.op inside {OP_OP, OP_BRANCH});
        req.ctrl.immed         = v.immed;
        {req.ctrl.reg_write, req.ctrl.mem_read, req.ctrl.mem_write} = v.flags;
        // Input jump_signal is a don't care
        req.ctrl.jump_signal   = fill[0];
    endtask

    // ------------------------------------------------------------------
    // One table row
    // ------------------------------------------------------------------

    task automatic run_vector(input int idx);
        vector_t      v;
        opcode_t      op;
        exec_result_t prev_result;
        exec_ctrl_t   exp_ctrl;
        int           cycles;
        int           extra_done;
        int           errors_before;
        logic         seen;
        v             = vectors[idx];
        op            = v.op;
        prev_result   = result;
        errors_before = errors;
        @(posedge clk);
        #1;
        load_request(v);
        execute_enable = 1'b1;
        cycles = 0;
        seen   = 1'b0;
        // Cycle 1 is CALC; extra enable or flush lives only there
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            #1;
            execute_enable = (cycles == 1) && (v.mode == MODE_EXTRA);
            flush          = (cycles == 1) && (v.mode == MODE_FLUSH);
            seen           = execute_done;
        end
        if (v.mode == MODE_FLUSH) begin
            if (seen) begin
                $display("Done pulse at %0t although flush was high in CALC", $time);
                errors++;
            end
            if (result !== prev_result) begin
                $display("[ERROR] %0t result got %h expected %h", $time, result, prev_result);
                errors++;
            end
        end else if (!seen) begin
            $display("Timeout at %0t: no execute_done within %0d cycles", $time, DONE_TIMEOUT);
            errors++;
        end else begin
            if (cycles != LATENCY) begin
                $display("Done after %0d cycles instead of %0d", cycles, LATENCY);
                errors++;
            end
            if (result.alu_result !== v.exp_result) begin
                report_mismatch("alu_result", result.alu_result, v.exp_result);
            end
            if (result.jump_taken !== v.exp_taken) begin
                report_mismatch("jump_taken", XLEN'(result.jump_taken), XLEN'(v.exp_taken));
            end
            if (result.jump_pc !== v.exp_target) begin
                report_mismatch("jump_pc", result.jump_pc, v.exp_target);
            end
            if (result.ctrl.jump_signal !== v.exp_taken) begin
                report_mismatch("jump_signal", XLEN'(result.ctrl.jump_signal),
                                XLEN'(v.exp_taken));
            end
            if ({result.ctrl.reg_write, result.ctrl.mem_read, result.ctrl.mem_write}
                    !== v.flags) begin
                report_mismatch("reg_write/mem_read/mem_write", XLEN'({result.ctrl.reg_write,
                                result.ctrl.mem_read, result.ctrl.mem_write}), XLEN'(v.flags));
            end
            // Whole control bundle comes back as sent, taken flag folded in
            exp_ctrl             = req.ctrl;
            exp_ctrl.jump_signal = v.exp_taken;
            if (result.ctrl !== exp_ctrl) begin
                $display("[ERROR] %0t ctrl got %h expected %h", $time, result.ctrl, exp_ctrl);
                errors++;
            end
            // Single pulse only, a second one means the extra enable got in
            extra_done = 0;
            repeat (4) begin
                @(posedge clk);
                #1;
                if (execute_done) begin
                    extra_done++;
                end
            end
            if (extra_done != 0) begin
                $display("Extra execute_done pulses seen: %0d", extra_done);
                errors++;
            end
        end
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("test %0d %s mode %0d: %s", idx, op.name(), v.mode,
                 (errors == errors_before) ? "ok" : "FAIL");
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        seed_value     = $urandom(32'h6a701173);
        clk            = 1'b0;
        reset          = 1'b1;
        execute_enable = 1'b0;
        flush          = 1'b0;
        req            = '0;
        errors         = 0;
        failed_tests   = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // Post-reset state
        if (execute_done !== 1'b0) begin
            report_mismatch("execute_done", XLEN'(execute_done), '0);
        end
        if (result !== '0) begin
            $display("[ERROR] %0t result got %h expected 0", $time, result);
            errors++;
        end
        $display("reset: %s", (errors == 0) ? "ok" : "FAIL");
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(i);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_VECTORS, failed_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   execute_enable,
    input  logic                   flush,
    input  exec_pkg::exec_req_t    req,
    output exec_pkg::exec_result_t result,
    output logic                   execute_done
);

    import exec_pkg::*;

    // ------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------

    // Control strobes
    logic            capture;
    logic            retire;

    // Held request and ALU path
    exec_req_t       held_req;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    alu_op_t         alu_op;
    logic [XLEN-1:0] alu_result;

    // ------------------------------------------------------------------
    // Instances
    // ------------------------------------------------------------------

    // IDLE/CALC sequencing and flush
    exec_control i_exec_control (
        .clk            (clk),
        .reset          (reset),
        .execute_enable (execute_enable),
        .flush          (flush),
        .capture        (capture),
        .retire         (retire)
    );

    // Capture at edge N, operands from the held copy
    operand_select i_operand_select (
        .clk       (clk),
        .reset     (reset),
        .capture   (capture),
        .req       (req),
        .held_req  (held_req),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .alu_op    (alu_op)
    );

    // Pure combinational
    int_alu i_int_alu (
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    // Jump resolve, result registered at edge N+1
    exec_retire i_exec_retire (
        .clk          (clk),
        .reset        (reset),
        .retire       (retire),
        .held_req     (held_req),
        .alu_result   (alu_result),
        .result       (result),
        .execute_done (execute_done)
    );

endmodule

/* hw/exec_retire.sv */
`timescale 1ns/1ps

module exec_retire (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      retire,
    input  exec_pkg::exec_req_t       held_req,
    input  logic [exec_pkg::XLEN-1:0] alu_result,
    output exec_pkg::exec_result_t    result,
    output logic                      execute_done
);

    import exec_pkg::*;

    logic            taken;
    logic [XLEN-1:0] target_base;
    logic [XLEN-1:0] target;
    exec_ctrl_t      ctrl_out;

    // ------------------------------------------------------------------
    // Jump resolution
    // ------------------------------------------------------------------

    always_comb begin
        case (held_req.ctrl.jump_if)
            JUMP_YES: taken = 1'b1;
            // All branch kinds reduce to a 0/1 compare
            JUMP_BR:  taken = alu_result == XLEN'(1);
            default:  taken = 1'b0;
        endcase
    end

    // JALR adds to rs1, branches and JAL add to pc
    assign target_base = held_req.ctrl.jump_absolute ? held_req.rs1_val : held_req.pc;

    // Target is zero when not taken
    assign target = taken ? target_base + held_req.ctrl.immed : '0;

    // Control passes through with the taken flag folded in
    always_comb begin
        ctrl_out             = held_req.ctrl;
        ctrl_out.jump_signal = taken;
    end

    // ------------------------------------------------------------------
    // Result register and done strobe
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            result       <= '0;
            execute_done <= 1'b0;
        end else if (retire) begin
            result.alu_result <= alu_result;
            result.jump_pc    <= target;
            result.jump_taken <= taken;
            result.ctrl       <= ctrl_out;
            execute_done      <= 1'b1;
        end else begin
            // Result holds, done is a single pulse
            execute_done <= 1'b0;
        end
    end

endmodule

/* hw/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
    input  logic [exec_pkg::XLEN-1:0] operand_a,
    input  logic [exec_pkg::XLEN-1:0] operand_b,
    input  exec_pkg::alu_op_t         alu_op,
    output logic [exec_pkg::XLEN-1:0] alu_result
);

    import exec_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               equal;

    // ------------------------------------------------------------------
    // Shared compare and shift terms
    // ------------------------------------------------------------------

    // Only low 6 bits count for RV64 shifts
    assign shamt = operand_b[SHAMT_W-1:0];

    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;
    assign equal       = operand_a == operand_b;

    // ------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = operand_a + operand_b;
            ALU_SUB: alu_result = operand_a - operand_b;
            ALU_AND: alu_result = operand_a & operand_b;
            ALU_OR:  alu_result = operand_a | operand_b;
            ALU_XOR: alu_result = operand_a ^ operand_b;
            ALU_SLL: alu_result = operand_a << shamt;
            ALU_SRL: alu_result = operand_a >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA: alu_result = $signed(operand_a) >>> shamt;
            // Compares give 0 or 1
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            // Branch compares, 1 means taken
            ALU_EQ: begin
                alu_result = {{(XLEN-1){1'b0}}, equal};
            end
            ALU_NE: begin
                alu_result = {{(XLEN-1){1'b0}}, !equal};
            end
            ALU_GE: begin
                alu_result = {{(XLEN-1){1'b0}}, !lt_signed};
            end
            ALU_GEU: begin
                alu_result = {{(XLEN-1){1'b0}}, !lt_unsigned};
            end
            // Unused codes
            default: alu_result = '0;
        endcase
    end

endmodule

/* hw/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      capture,
    input  exec_pkg::exec_req_t       req,
    output exec_pkg::exec_req_t       held_req,
    output logic [exec_pkg::XLEN-1:0] operand_a,
    output logic [exec_pkg::XLEN-1:0] operand_b,
    output exec_pkg::alu_op_t         alu_op
);

    import exec_pkg::*;

    // ------------------------------------------------------------------
    // Request register
    // ------------------------------------------------------------------

    // Loaded in the enable cycle, held through CALC and after
    always_ff @(posedge clk) begin
        if (reset) begin
            held_req <= '0;
        end else if (capture) begin
            held_req <= req;
        end
    end

    // ------------------------------------------------------------------
    // Operand choice by opcode
    // ------------------------------------------------------------------

    always_comb begin
        // Register-register by default
        operand_a = held_req.rs1_val;
        operand_b = held_req.rs2_val;
        case (held_req.ctrl.op_code)
            OP_LUI: begin
                // Zero plus immediate
                operand_a = '0;
                operand_b = held_req.ctrl.immed;
            end
            OP_AUIPC: begin
                operand_a = held_req.pc;
                operand_b = held_req.ctrl.immed;
            end
            OP_JAL, OP_JALR: begin
                // Link address, pc + 4
                // Target comes from the retire stage
                operand_a = held_req.pc;
                operand_b = XLEN'(INSN_BYTES);
            end
            OP_BRANCH, OP_OP: begin
                operand_a = held_req.rs1_val;
                operand_b = held_req.rs2_val;
            end
            OP_OP_IMM, OP_LOAD, OP_STORE: begin
                // Address or immediate arithmetic
                operand_a = held_req.rs1_val;
                operand_b = held_req.ctrl.immed;
            end
            default: begin
                // Unknown opcode, decoder flag picks b
                operand_a = held_req.rs1_val;
                if (held_req.ctrl.alu_use_immed) begin
                    operand_b = held_req.ctrl.immed;
                end else begin
                    operand_b = held_req.rs2_val;
                end
            end
        endcase
    end

    // ------------------------------------------------------------------
    // ALU operation
    // ------------------------------------------------------------------

    always_comb begin
        case (held_req.ctrl.op_code)
            // Address and link forms always add
            OP_LOAD, OP_STORE, OP_JAL, OP_JALR, OP_AUIPC: begin
                alu_op = ALU_ADD;
            end
            default: begin
                alu_op = held_req.ctrl.alu_op;
            end
        endcase
    end

endmodule

/* hw/exec_control.sv */
`timescale 1ns/1ps

module exec_control (
    input  logic clk,
    input  logic reset,
    input  logic execute_enable,
    input  logic flush,
    output logic capture,
    output logic retire
);

    import exec_pkg::*;

    exec_state_t state;
    exec_state_t state_next;

    // ------------------------------------------------------------------
    // Next state and strobes
    // ------------------------------------------------------------------

    always_comb begin
        state_next = state;
        capture    = 1'b0;
        retire     = 1'b0;
        case (state)
            EXEC_IDLE: begin
                // Flush wins over enable
                if (execute_enable && !flush) begin
                    capture    = 1'b1;
                    state_next = EXEC_CALC;
                end
            end
            EXEC_CALC: begin
                // One cycle of compute, then back
                // Enable pulses here are dropped
                retire     = !flush;
                state_next = EXEC_IDLE;
            end
            default: begin
                state_next = EXEC_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EXEC_IDLE;
        end else if (flush) begin
            // Abort anything in flight
            state <= EXEC_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* hw/exec_pkg.sv */
package exec_pkg;

    // ------------------------------------------------------------------
    // Widths and constants
    // ------------------------------------------------------------------

    // Data and address width
    localparam int XLEN = 64;

    // Link address step for JAL and JALR
    localparam int INSN_BYTES = 4;

    // Shift amount field width, low bits of operand b
    localparam int SHAMT_W = $clog2(XLEN);

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------

    // Major opcodes, real RV64I encodings
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcode_t;

    // ALU operations
    // BLT and BLTU go through SLT and SLTU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_EQ   = 4'd10,
        ALU_NE   = 4'd11,
        ALU_GE   = 4'd12,
        ALU_GEU  = 4'd13
    } alu_op_t;

    // Jump conditions
    // BR is taken when the ALU compare returns 1
    typedef enum logic [2:0] {
        JUMP_NONE = 3'd0,
        JUMP_YES  = 3'd1,
        JUMP_BR   = 3'd2
    } jump_cond_t;

    // Control machine states
    typedef enum logic {
        EXEC_IDLE = 1'b0,
        EXEC_CALC = 1'b1
    } exec_state_t;

    // ------------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------------

    // Decoder control, passed through to the result
    typedef struct packed {
        opcode_t           op_code;
        alu_op_t           alu_op;
        jump_cond_t        jump_if;
        logic              jump_absolute;  // Target from rs1, JALR style
        logic              alu_use_immed;
        logic [XLEN-1:0]   immed;          // Already sign-extended
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              jump_signal;    // Don't care in, taken flag out
    } exec_ctrl_t;

    // One decoded instruction
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs1_val;
        logic [XLEN-1:0]   rs2_val;
        exec_ctrl_t        ctrl;
    } exec_req_t;

    // Retired result
    typedef struct packed {
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   jump_pc;
        logic              jump_taken;
        exec_ctrl_t        ctrl;
    } exec_result_t;

endpackage
